// File: compile.f
gcd_pkg.sv
queue_ptr.sv
normal_queue.sv
gcd_ctrl.sv
gcd_dpath.sv
gcd_top.sv
tb_gcd_top.sv

// File: run_sim.sh
#!/bin/sh
# build the gcd testbench with Verilator, run it, and
# decide pass or fail from the printed output

verilator --binary --timing -f compile.f --top-module tb_gcd_top -o sim_gcd \
  && out=$(./obj_dir/sim_gcd) \
  && echo "$out" \
  && echo "$out" | grep -qx "Simulation passed" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

exit 0

// File: tb_gcd_top.sv
//--------------------------------------------------
// gcd top testbench
// directed tests through the request and response
// queues, results checked against Euclid's GCD
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_gcd_top;

  import gcd_pkg::*;

  localparam int p_num_entries = 2;
  // two per queue plus one held in the engine
  localparam int max_accept    = 2*p_num_entries+1;
  // longest calc is about 65535 subtracts
  localparam int idle_limit    = 140000;

  logic                 clk;
  logic                 reset;
  logic                 req_val;
  logic                 req_rdy;
  gcd_req_u             req_msg;
  logic                 resp_val;
  logic                 resp_rdy;
  logic [gcd_nbits-1:0] resp_msg;

  // requests not yet sent, results not yet seen
  gcd_req_t             ops_q[$];
  logic [gcd_nbits-1:0] exp_q[$];

  int   err_count;
  int   err_mark;
  int   check_count;
  int   tests_run;
  logic hung;

  gcd_top #(
    .p_num_entries (p_num_entries)
  ) uut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //------------------------------------------------
  // helpers
  //------------------------------------------------

  // reference model, remainder form of Euclid
  function automatic logic [gcd_nbits-1:0] euclid_gcd(input logic [gcd_nbits-1:0] x,
                                                      input logic [gcd_nbits-1:0] y);
    logic [gcd_nbits-1:0] u;
    logic [gcd_nbits-1:0] v;
    logic [gcd_nbits-1:0] t;
    u = x;
    v = y;
    while (v != '0) begin
      t = u % v;
      u = v;
      v = t;
    end
    return u;
  endfunction

  task automatic compare_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic queue_request(input logic [gcd_nbits-1:0] a, input logic [gcd_nbits-1:0] b);
    gcd_req_t r;
    r.a = a;
    r.b = b;
    ops_q.push_back(r);
  endtask

  // one line per test, errors since the last report
  task automatic report_test(input string name);
    tests_run++;
    $display("test %0d %s finished, %0d errors", tests_run, name, err_count - err_mark);
    err_mark = err_count;
  endtask

  // feeds ops_q and drains exp_q, resp_rdy high rdy_pct percent of cycles
  task automatic drive_traffic(input int rdy_pct);
    int                   idle;
    gcd_req_t             head;
    logic [gcd_nbits-1:0] exp;
    idle = 0;
    while ((ops_q.size() != 0 || exp_q.size() != 0) && !hung) begin
      @(negedge clk);
      // head request held until it is taken
      if (ops_q.size() != 0) begin
        head        = ops_q[0];
        req_msg.ops = head;
        req_val     = 1'b1;
      end else begin
        req_val = 1'b0;
      end
      resp_rdy = (($urandom % 100) < rdy_pct);
      // rdy/val are register outputs, so these fire at the next edge
      if (req_val && req_rdy) begin
        exp_q.push_back(euclid_gcd(head.a, head.b));
        ops_q.delete(0);
      end
      if (resp_val && resp_rdy) begin
        idle = 0;
        if (exp_q.size() == 0) begin
          $display("response 0x%0h arrived with no request outstanding", resp_msg);
          err_count++;
        end else begin
          exp = exp_q.pop_front();
          compare_val("resp_msg", 32'(resp_msg), 32'(exp));
        end
      end else begin
        idle++;
      end
      if (idle > idle_limit) begin
        $display("timeout: no response within %0d cycles", idle_limit);
        hung = 1'b1;
      end
    end
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic single_request(input logic [gcd_nbits-1:0] a, input logic [gcd_nbits-1:0] b);
    queue_request(a, b);
    drive_traffic(100);
  endtask

  //------------------------------------------------
  // tests
  //------------------------------------------------

  task automatic check_reset_state();
    @(negedge clk);
    compare_val("req_rdy", 32'(req_rdy), 32'd1);
    compare_val("resp_val", 32'(resp_val), 32'd0);
    report_test("reset_state");
  endtask

  task automatic reference_vectors();
    single_request(16'd15, 16'd10);
    single_request(16'd22, 16'd10);
    single_request(16'd36, 16'd18);
    single_request(16'd36, 16'd21);
    report_test("reference_vectors");
  endtask

  task automatic edge_operands();
    single_request(16'd0, 16'd0);
    single_request(16'd7, 16'd0);
    single_request(16'd0, 16'd9);
    single_request(16'd1, 16'd65535);
    single_request(16'd65535, 16'd65535);
    single_request(16'd40000, 16'd2);
    report_test("edge_operands");
  endtask

  // sink stalled, count how many requests get in
  task automatic back_pressure();
    int       accepted;
    int       low_run;
    int       cycles;
    gcd_req_t head;
    queue_request(16'd12, 16'd8);
    queue_request(16'd9, 16'd6);
    queue_request(16'd100, 16'd75);
    queue_request(16'd21, 16'd14);
    queue_request(16'd49, 16'd35);
    queue_request(16'd17, 16'd5);
    queue_request(16'd30, 16'd12);
    accepted = 0;
    low_run  = 0;
    cycles   = 0;
    while (low_run < 40 && ops_q.size() != 0 && cycles < 2000) begin
      @(negedge clk);
      cycles++;
      resp_rdy    = 1'b0;
      head        = ops_q[0];
      req_msg.ops = head;
      req_val     = 1'b1;
      if (req_rdy) begin
        accepted++;
        low_run = 0;
        exp_q.push_back(euclid_gcd(head.a, head.b));
        ops_q.delete(0);
      end else begin
        low_run++;
      end
    end
    if (low_run < 40) begin
      $display("req_rdy never stayed low with resp_rdy held low");
      err_count++;
    end
    if (accepted > max_accept) begin
      $display("%0d requests accepted under back-pressure, at most %0d allowed",
               accepted, max_accept);
      err_count++;
    end
    // release the sink, everything must drain in order
    drive_traffic(100);
    report_test("back_pressure");
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    repeat (30) begin
      r = $urandom;
      queue_request(r[31:16], r[15:0]);
    end
    drive_traffic(50);
    report_test("random_traffic");
  endtask

  //------------------------------------------------
  // main sequence
  //------------------------------------------------

  initial begin
    void'($urandom(78));
    err_count   = 0;
    err_mark    = 0;
    check_count = 0;
    tests_run   = 0;
    hung        = 1'b0;
    reset       = 1'b1;
    req_val     = 1'b0;
    req_msg     = '0;
    resp_rdy    = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    check_reset_state();
    if (!hung) reference_vectors();
    if (!hung) edge_operands();
    if (!hung) back_pressure();
    if (!hung) random_traffic();

    $display("tests run %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
    if (hung || err_count != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: gcd_top.sv
//--------------------------------------------------
// gcd top
// request queue -> GCD engine -> response queue,
// all on one clock
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module gcd_top #(
  parameter int p_num_entries = 2
) (
  input  wire                            clk,
  input  wire                            reset,
  input  wire                            req_val,
  output logic                           req_rdy,
  input  wire  gcd_pkg::gcd_req_u        req_msg,
  output logic                           resp_val,
  input  wire                            resp_rdy,
  output logic [gcd_pkg::gcd_nbits-1:0]  resp_msg
);

  import gcd_pkg::*;

  // request queue to engine
  logic        eng_req_val;
  logic        eng_req_rdy;
  gcd_req_u    eng_req;

  // engine to response queue
  logic                 eng_resp_val;
  logic                 eng_resp_rdy;
  logic [gcd_nbits-1:0] eng_result;

  // control <-> datapath
  gcd_ctrl_t   ctrl;
  gcd_status_t status;

  //------------------------------------------------
  // request side
  //------------------------------------------------

  // queue carries the raw word, the datapath reads ops
  normal_queue #(
    .p_data_width  ($bits(gcd_req_u)),
    .p_num_entries (p_num_entries)
  ) req_queue (
    .clk   (clk),
    .reset (reset),
    .w_val (req_val),
    .w_rdy (req_rdy),
    .w_msg (req_msg.raw),
    .r_val (eng_req_val),
    .r_rdy (eng_req_rdy),
    .r_msg (eng_req.raw)
  );

  //------------------------------------------------
  // engine
  //------------------------------------------------

  gcd_ctrl ctrl_unit (
    .clk      (clk),
    .reset    (reset),
    .req_val  (eng_req_val),
    .req_rdy  (eng_req_rdy),
    .resp_val (eng_resp_val),
    .resp_rdy (eng_resp_rdy),
    .status   (status),
    .ctrl     (ctrl)
  );

  gcd_dpath dpath (
    .clk    (clk),
    .req    (eng_req),
    .ctrl   (ctrl),
    .status (status),
    .result (eng_result)
  );

  // response side
  normal_queue #(
    .p_data_width  (gcd_nbits),
    .p_num_entries (p_num_entries)
  ) resp_queue (
    .clk   (clk),
    .reset (reset),
    .w_val (eng_resp_val),
    .w_rdy (eng_resp_rdy),
    .w_msg (eng_result),
    .r_val (resp_val),
    .r_rdy (resp_rdy),
    .r_msg (resp_msg)
  );

endmodule

`default_nettype wire

// File: gcd_dpath.sv
//--------------------------------------------------
// gcd datapath
// A/B operand registers, input muxes, subtractor
// and the compare flags for the control
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module gcd_dpath (
  input  wire                          clk,
  input  wire  gcd_pkg::gcd_req_u      req,
  input  wire  gcd_pkg::gcd_ctrl_t     ctrl,
  output gcd_pkg::gcd_status_t         status,
  output logic [gcd_pkg::gcd_nbits-1:0] result
);

  import gcd_pkg::*;

  logic [gcd_nbits-1:0] a_reg;
  logic [gcd_nbits-1:0] b_reg;
  logic [gcd_nbits-1:0] a_mux;
  logic [gcd_nbits-1:0] b_mux;
  logic [gcd_nbits-1:0] diff;

  //------------------------------------------------
  // input muxes
  //------------------------------------------------

  always_comb begin
    case (ctrl.a_sel)
      a_sel_in:  a_mux = req.ops.a;
      a_sel_sub: a_mux = diff;
      a_sel_b:   a_mux = b_reg;
      default:   a_mux = req.ops.a;
    endcase
  end

  // b takes old a on a swap
  assign b_mux = (ctrl.b_sel == b_sel_in) ? req.ops.b : a_reg;

  //------------------------------------------------
  // operand registers
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.a_en) begin
      a_reg <= a_mux;
    end
    if (ctrl.b_en) begin
      b_reg <= b_mux;
    end
  end

  // subtract and compare
  assign diff          = a_reg - b_reg;
  assign status.a_lt_b = (a_reg < b_reg);
  assign status.b_zero = (b_reg == '0);

  // with b at zero the difference is the gcd
  assign result = diff;

endmodule

`default_nettype wire

// File: gcd_ctrl.sv
//--------------------------------------------------
// gcd control unit
// IDLE/CALC/DONE FSM, steers the datapath and
// runs the engine-side valid/ready handshake
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module gcd_ctrl (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  req_val,
  output logic                 req_rdy,
  output logic                 resp_val,
  input  wire                  resp_rdy,
  input  wire  gcd_pkg::gcd_status_t status,
  output gcd_pkg::gcd_ctrl_t   ctrl
);

  import gcd_pkg::*;

  gcd_state_e state;
  gcd_state_e state_next;

  //------------------------------------------------
  // state register
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  //------------------------------------------------
  // next state
  //------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      // take a request off the queue
      idle: if (req_val && req_rdy) state_next = calc;
      // finished once b reaches zero
      calc: if (!status.a_lt_b && status.b_zero) state_next = done;
      // wait for the response queue
      done: if (resp_val && resp_rdy) state_next = idle;
      default: state_next = idle;
    endcase
  end

  //------------------------------------------------
  // outputs
  //------------------------------------------------

  always_comb begin
    req_rdy    = 1'b0;
    resp_val   = 1'b0;
    ctrl.a_sel = a_sel_in;
    ctrl.a_en  = 1'b0;
    ctrl.b_sel = b_sel_in;
    ctrl.b_en  = 1'b0;
    case (state)
      idle: begin
        // load both operands from the request word
        req_rdy    = 1'b1;
        ctrl.a_sel = a_sel_in;
        ctrl.a_en  = 1'b1;
        ctrl.b_sel = b_sel_in;
        ctrl.b_en  = 1'b1;
      end
      calc: begin
        // swap when a < b, else a <= a - b
        ctrl.a_sel = status.a_lt_b ? a_sel_b : a_sel_sub;
        ctrl.a_en  = 1'b1;
        ctrl.b_sel = b_sel_a;
        ctrl.b_en  = status.a_lt_b;
      end
      done: resp_val = 1'b1;
      default: req_rdy = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: normal_queue.sv
//--------------------------------------------------
// normal queue
// single-clock FIFO with valid/ready on both sides
// and a combinational read port
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module normal_queue #(
  parameter int p_data_width  = 32,
  parameter int p_num_entries = 2
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     w_val,
  output logic                    w_rdy,
  input  wire  [p_data_width-1:0] w_msg,
  output logic                    r_val,
  input  wire                     r_rdy,
  output logic [p_data_width-1:0] r_msg
);

  localparam int p_idx_bits = $clog2(p_num_entries);

  logic                  w_go;
  logic                  r_go;
  logic [p_idx_bits-1:0] w_idx;
  logic [p_idx_bits-1:0] r_idx;
  logic                  full;
  logic                  empty;

  // storage
  logic [p_data_width-1:0] mem [p_num_entries];

  // transfer strobes
  assign w_go = w_val && w_rdy;
  assign r_go = r_val && r_rdy;

  queue_ptr #(
    .p_num_entries (p_num_entries)
  ) ptr (
    .clk   (clk),
    .reset (reset),
    .w_go  (w_go),
    .r_go  (r_go),
    .w_idx (w_idx),
    .r_idx (r_idx),
    .full  (full),
    .empty (empty)
  );

  // write on handshake
  always_ff @(posedge clk) begin
    if (w_go) begin
      mem[w_idx] <= w_msg;
    end
  end

  // head entry visible a cycle after its write
  assign r_msg = mem[r_idx];
  assign w_rdy = !full;
  assign r_val = !empty;

endmodule

`default_nettype wire

// File: queue_ptr.sv
//--------------------------------------------------
// queue pointer counters
// write/read pointers with a wrap bit, giving the
// storage indices and the full/empty flags
//--------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module queue_ptr #(
  parameter int p_num_entries = 2
) (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 w_go,
  input  wire                                 r_go,
  output logic [$clog2(p_num_entries)-1:0]    w_idx,
  output logic [$clog2(p_num_entries)-1:0]    r_idx,
  output logic                                full,
  output logic                                empty
);

  // depth must be a power of two
  localparam int p_idx_bits = $clog2(p_num_entries);

  // one extra bit on top for the wrap
  logic [p_idx_bits:0] w_ptr;
  logic [p_idx_bits:0] r_ptr;

  always_ff @(posedge clk) begin
    if (reset) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      if (w_go) begin
        w_ptr <= w_ptr + 1'b1;
      end
      if (r_go) begin
        r_ptr <= r_ptr + 1'b1;
      end
    end
  end

  assign w_idx = w_ptr[p_idx_bits-1:0];
  assign r_idx = r_ptr[p_idx_bits-1:0];

  // same slot, writer one lap ahead
  assign full  = (w_idx == r_idx) && (w_ptr[p_idx_bits] != r_ptr[p_idx_bits]);
  // reader caught up completely
  assign empty = (w_ptr == r_ptr);

endmodule

`default_nettype wire

// File: gcd_pkg.sv
//--------------------------------------------------
// gcd shared types
// operand width, request word, control and status
// bundles, mux selects and FSM states
//--------------------------------------------------

`default_nettype none

package gcd_pkg;

  // operand and result width
  localparam int gcd_nbits = 16;

  // request operands, a in the upper half
  typedef struct packed {
    logic [gcd_nbits-1:0] a;
    logic [gcd_nbits-1:0] b;
  } gcd_req_t;

  // queue stores raw, datapath reads ops
  typedef union packed {
    logic [2*gcd_nbits-1:0] raw;
    gcd_req_t               ops;
  } gcd_req_u;

  //------------------------------------------------
  // mux selects
  //------------------------------------------------

  typedef enum logic [1:0] {
    a_sel_in  = 2'd0,
    a_sel_sub = 2'd1,
    a_sel_b   = 2'd2
  } a_sel_e;

  typedef enum logic {
    b_sel_a  = 1'b0,
    b_sel_in = 1'b1
  } b_sel_e;

  // control into datapath
  typedef struct packed {
    a_sel_e a_sel;
    logic   a_en;
    b_sel_e b_sel;
    logic   b_en;
  } gcd_ctrl_t;

  // status back to control
  typedef struct packed {
    logic a_lt_b;
    logic b_zero;
  } gcd_status_t;

  // engine FSM states
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } gcd_state_e;

endpackage

`default_nettype wire
